/* router_op_lut_pkg.sv */
package router_op_lut_pkg;

   //////////////////////////////////////////////////////////////////////
   // stream widths and constants
   //////////////////////////////////////////////////////////////////////
   localparam int data_width = 64;
   localparam int ctrl_width = 8;

   localparam logic [ctrl_width-1:0] ctrl_mod_hdr = 8'hFF; // module header marker
   localparam logic [15:0]           ethertype_ip = 16'h0800;
   localparam logic [47:0]           mac_broadcast = {48{1'b1}};

   // one stream word, ctrl on top
   typedef struct packed {
      logic [ctrl_width-1:0] ctrl; // 0 mid packet, ff header, other nonzero eop
      logic [data_width-1:0] data;
   } pkt_word_t;

   // word position in the packet, header words 0..5 then payload
   typedef enum logic [2:0] {
      w_mod_hdr,
      w_mac_da,
      w_mac_sa_type,
      w_ip_len_ttl,
      w_ip_cksum_src,
      w_ip_dst_lo,
      w_payload
   } word_sel_e;

   typedef enum logic [1:0] {
      act_forward,
      act_to_cpu,
      act_drop
   } action_e;

   //////////////////////////////////////////////////////////////////////
   // lookup side records
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic        valid;
      logic [31:0] prefix;
      logic [31:0] mask;
      logic [7:0]  oq;     // one-hot output queue
   } route_entry_t;

   typedef struct packed {
      logic [31:0] dst_ip;
      logic        for_us;       // da matches router mac
      logic        is_broadcast;
      logic        is_ip;
      logic        ip_hdr_ok;    // v4, ihl 5
      logic        ttl_ok;       // ttl > 1
   } hdr_info_t;

   typedef struct packed {
      action_e     action;
      logic [7:0]  out_port;
   } lookup_result_t;

endpackage

/* small_fifo.sv */
`timescale 1ns/1ps

module small_fifo #(
   parameter int width      = 72,
   parameter int depth_bits = 5
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [width-1:0] din,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [width-1:0] dout,
   output logic             empty,
   output logic             nearly_full
);

   localparam int depth = 1 << depth_bits;

   logic [width-1:0]      mem [depth];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;  // one extra bit so full fits
   logic [depth_bits:0]   free;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign full  = (count == depth[depth_bits:0]);
   assign empty = (count == '0);
   assign free  = depth[depth_bits:0] - count;
   assign nearly_full = (free <= 4);  // room for the sender's late words

   assign do_wr = wr_en && !full;   // overflow writes are lost
   assign do_rd = rd_en && !empty;

   assign dout = mem[rd_ptr];       // fallthrough, head always visible

   always_ff @(posedge clk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

endmodule

/* pkt_word_counter.sv */
`timescale 1ns/1ps

module pkt_word_counter (
   input  logic                          clk,
   input  logic                          rst_n,
   input  router_op_lut_pkg::pkt_word_t  word,
   input  logic                          advance,
   output router_op_lut_pkg::word_sel_e  word_sel
);

   logic is_eop;

   // last word has a nonzero ctrl that is not the header marker
   assign is_eop = (word.ctrl != '0) && (word.ctrl != router_op_lut_pkg::ctrl_mod_hdr);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_sel <= router_op_lut_pkg::w_mod_hdr;
      end else if (advance) begin
         if (is_eop) begin
            word_sel <= router_op_lut_pkg::w_mod_hdr;   // next word starts a packet
         end else if (word_sel != router_op_lut_pkg::w_payload) begin
            word_sel <= router_op_lut_pkg::word_sel_e'(word_sel + 3'd1);
         end
         // past word 5 we just sit on w_payload
      end
   end

endmodule

/* hdr_parser.sv */
`timescale 1ns/1ps

module hdr_parser (
   input  logic                          clk,
   input  logic                          rst_n,
   input  router_op_lut_pkg::pkt_word_t  in_word,
   input  logic                          in_wr,
   input  router_op_lut_pkg::word_sel_e  word_sel,
   input  logic [47:0]                   router_mac,
   output router_op_lut_pkg::hdr_info_t  hdr_info,
   output logic                          hdr_vld
);

   localparam logic [7:0] ip_ver_ihl = 8'h45;  // v4, 20 byte header

   //////////////////////////////////////////////////////////////////////
   // field taps on the incoming data word
   //////////////////////////////////////////////////////////////////////
   logic [47:0] mac_da;
   logic [15:0] ethertype;
   logic [7:0]  ver_ihl;
   logic [7:0]  ttl;
   logic [15:0] dst_ip_hi;
   logic [15:0] dst_ip_lo;

   assign mac_da    = in_word.data[63:16];  // word 1
   assign ethertype = in_word.data[31:16];  // word 2
   assign ver_ihl   = in_word.data[15:8];   // word 2
   assign ttl       = in_word.data[15:8];   // word 3
   assign dst_ip_hi = in_word.data[15:0];   // word 4 tail
   assign dst_ip_lo = in_word.data[63:48];  // word 5 head

   logic wr_da;
   logic wr_type;
   logic wr_ttl;
   logic wr_ip_hi;
   logic wr_ip_lo;

   assign wr_da    = in_wr && (word_sel == router_op_lut_pkg::w_mac_da);
   assign wr_type  = in_wr && (word_sel == router_op_lut_pkg::w_mac_sa_type);
   assign wr_ttl   = in_wr && (word_sel == router_op_lut_pkg::w_ip_len_ttl);
   assign wr_ip_hi = in_wr && (word_sel == router_op_lut_pkg::w_ip_cksum_src);
   assign wr_ip_lo = in_wr && (word_sel == router_op_lut_pkg::w_ip_dst_lo);

   // flags and ip held until the next packet overwrites them
   always_ff @(posedge clk) begin
      if (wr_da) begin
         hdr_info.for_us       <= (mac_da == router_mac);
         hdr_info.is_broadcast <= (mac_da == router_op_lut_pkg::mac_broadcast);
      end
      if (wr_type) begin
         hdr_info.is_ip     <= (ethertype == router_op_lut_pkg::ethertype_ip);
         hdr_info.ip_hdr_ok <= (ver_ihl == ip_ver_ihl);   // options or v6 fail here
      end
      if (wr_ttl) hdr_info.ttl_ok <= (ttl > 8'd1);
      if (wr_ip_hi) hdr_info.dst_ip[31:16] <= dst_ip_hi;
      if (wr_ip_lo) hdr_info.dst_ip[15:0] <= dst_ip_lo;
   end

   // all fields settle on the word 5 edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hdr_vld <= 1'b0;
      end else begin
         hdr_vld <= wr_ip_lo;   // single cycle pulse
      end
   end

endmodule

/* ip_lpm.sv */
`timescale 1ns/1ps

module ip_lpm #(
   parameter int num_queues = 8,
   parameter int cpu_port   = 0,
   parameter int lut_depth  = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              rt_wr_req,
   input  logic [1:0]                        rt_wr_addr,
   input  router_op_lut_pkg::route_entry_t   rt_wr_entry,
   output logic                              rt_wr_ack,
   input  router_op_lut_pkg::hdr_info_t      hdr_info,
   input  logic                              hdr_vld,
   output router_op_lut_pkg::lookup_result_t result,
   output logic                              result_vld
);

   localparam logic [num_queues-1:0] cpu_oq = num_queues'(1) << cpu_port;

   router_op_lut_pkg::route_entry_t rt_mem [lut_depth];

   //////////////////////////////////////////////////////////////////////
   // table write, ack one cycle after req
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rt_wr_ack <= 1'b0;
         for (int i = 0; i < lut_depth; i++) rt_mem[i] <= '0;  // all invalid
      end else begin
         rt_wr_ack <= rt_wr_req && !rt_wr_ack;   // drops while req is still held
         if (rt_wr_req && !rt_wr_ack) rt_mem[rt_wr_addr] <= rt_wr_entry;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // prefix match, lowest index wins
   //////////////////////////////////////////////////////////////////////
   logic       lpm_hit;
   logic [7:0] lpm_oq;
   router_op_lut_pkg::lookup_result_t next_result;

   always_comb begin
      lpm_hit = 1'b0;
      lpm_oq  = '0;
      for (int i = lut_depth - 1; i >= 0; i--) begin   // later hits override
         if (rt_mem[i].valid && ((hdr_info.dst_ip & rt_mem[i].mask) == rt_mem[i].prefix)) begin
            lpm_hit = 1'b1;
            lpm_oq  = rt_mem[i].oq;
         end
      end
   end

   always_comb begin
      if (!hdr_info.for_us && !hdr_info.is_broadcast) begin
         next_result.action   = router_op_lut_pkg::act_drop;   // not addressed to us
         next_result.out_port = '0;
      end else if (hdr_info.is_broadcast || !hdr_info.is_ip || !hdr_info.ip_hdr_ok ||
                   !hdr_info.ttl_ok || !lpm_hit) begin
         next_result.action   = router_op_lut_pkg::act_to_cpu;
         next_result.out_port = 8'(cpu_oq);
      end else begin
         next_result.action   = router_op_lut_pkg::act_forward;
         next_result.out_port = lpm_oq;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_vld) result <= next_result;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) result_vld <= 1'b0;
      else        result_vld <= hdr_vld;   // push into decision fifo
   end

endmodule

/* op_lut_process_sm.sv */
`timescale 1ns/1ps

module op_lut_process_sm (
   input  logic                              clk,
   input  logic                              rst_n,
   input  router_op_lut_pkg::pkt_word_t      fifo_word,
   input  logic                              fifo_empty,
   output logic                              fifo_rd_en,
   input  router_op_lut_pkg::lookup_result_t result,
   input  logic                              result_empty,
   output logic                              result_rd_en,
   output router_op_lut_pkg::pkt_word_t      out_word,
   output logic                              out_wr,
   input  logic                              out_rdy
);

   typedef enum logic [1:0] {
      st_idle,
      st_move,
      st_drop
   } state_e;

   state_e                        state;
   state_e                        state_nxt;
   router_op_lut_pkg::action_e    act_q;      // decision of the packet in flight
   router_op_lut_pkg::word_sel_e  word_sel;   // position of the fifo head

   logic        is_hdr;
   logic        is_eop;
   logic [16:0] cksum_sum;
   logic [15:0] cksum_new;

   // output side position tracker, advances on every read
   pkt_word_counter i_out_counter (
      .clk      (clk),
      .rst_n    (rst_n),
      .word     (fifo_word),
      .advance  (fifo_rd_en),
      .word_sel (word_sel)
   );

   assign is_hdr = (fifo_word.ctrl == router_op_lut_pkg::ctrl_mod_hdr);
   assign is_eop = (fifo_word.ctrl != '0) && !is_hdr;

   // ttl drops by one so the checksum goes up by 0x0100, end-around carry
   assign cksum_sum = {1'b0, fifo_word.data[63:48]} + 17'h00100;
   assign cksum_new = cksum_sum[15:0] + {15'd0, cksum_sum[16]};

   //////////////////////////////////////////////////////////////////////
   // next state and read / write strobes
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      state_nxt    = state;
      fifo_rd_en   = 1'b0;
      result_rd_en = 1'b0;
      out_wr       = 1'b0;
      out_word     = fifo_word;
      case (state)
         st_idle: begin
            // header at head plus its decision, and room downstream
            if (!fifo_empty && !result_empty && is_hdr && out_rdy) begin
               fifo_rd_en   = 1'b1;
               result_rd_en = 1'b1;
               if (result.action == router_op_lut_pkg::act_drop) begin
                  state_nxt = st_drop;
               end else begin
                  out_wr             = 1'b1;
                  out_word.data[7:0] = result.out_port;   // one-hot port
                  state_nxt          = st_move;
               end
            end
         end
         st_move: begin
            if (!fifo_empty && out_rdy) begin
               fifo_rd_en = 1'b1;
               out_wr     = 1'b1;
               if (act_q == router_op_lut_pkg::act_forward) begin
                  if (word_sel == router_op_lut_pkg::w_ip_len_ttl)
                     out_word.data[15:8] = fifo_word.data[15:8] - 8'd1;
                  if (word_sel == router_op_lut_pkg::w_ip_cksum_src)
                     out_word.data[63:48] = cksum_new;
               end
               if (is_eop) state_nxt = st_idle;
            end
         end
         st_drop: begin
            if (!fifo_empty && out_rdy) begin
               fifo_rd_en = 1'b1;   // read and discard
               if (is_eop) state_nxt = st_idle;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
         act_q <= router_op_lut_pkg::act_drop;
      end else begin
         state <= state_nxt;
         if (result_rd_en) act_q <= result.action;   // latched with the header
      end
   end

endmodule

/* router_op_lut.sv */
`timescale 1ns/1ps

module router_op_lut #(
   parameter int num_queues = 8,
   parameter int cpu_port   = 0,
   parameter int lut_depth  = 4
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  router_op_lut_pkg::pkt_word_t      in_word,
   input  logic                              in_wr,
   output logic                              in_rdy,
   output router_op_lut_pkg::pkt_word_t      out_word,
   output logic                              out_wr,
   input  logic                              out_rdy,
   input  logic [47:0]                       router_mac,
   input  logic                              rt_wr_req,
   input  logic [1:0]                        rt_wr_addr,
   input  router_op_lut_pkg::route_entry_t   rt_wr_entry,
   output logic                              rt_wr_ack
);

   localparam int word_w = $bits(router_op_lut_pkg::pkt_word_t);
   localparam int res_w  = $bits(router_op_lut_pkg::lookup_result_t);

   router_op_lut_pkg::pkt_word_t      fifo_word;
   router_op_lut_pkg::word_sel_e      in_word_sel;
   router_op_lut_pkg::hdr_info_t      hdr_info;
   router_op_lut_pkg::lookup_result_t lpm_result;
   router_op_lut_pkg::lookup_result_t fifo_result;
   logic fifo_empty, fifo_rd_en, fifo_nearly_full;
   logic hdr_vld, lpm_result_vld;
   logic result_empty, result_rd_en;

   assign in_rdy = !fifo_nearly_full;

   //////////////////////////////////////////////////////////////////////
   // input side, words buffered while the header is parsed
   //////////////////////////////////////////////////////////////////////
   small_fifo #(.width(word_w), .depth_bits(5)) i_word_fifo (
      .clk (clk), .rst_n (rst_n), .din (in_word), .wr_en (in_wr),
      .rd_en (fifo_rd_en), .dout (fifo_word), .empty (fifo_empty),
      .nearly_full (fifo_nearly_full)
   );

   pkt_word_counter i_in_counter (
      .clk (clk), .rst_n (rst_n), .word (in_word), .advance (in_wr), .word_sel (in_word_sel)
   );

   hdr_parser i_hdr_parser (
      .clk (clk), .rst_n (rst_n), .in_word (in_word), .in_wr (in_wr),
      .word_sel (in_word_sel), .router_mac (router_mac),
      .hdr_info (hdr_info), .hdr_vld (hdr_vld)
   );

   ip_lpm #(.num_queues(num_queues), .cpu_port(cpu_port), .lut_depth(lut_depth)) i_ip_lpm (
      .clk (clk), .rst_n (rst_n), .rt_wr_req (rt_wr_req), .rt_wr_addr (rt_wr_addr),
      .rt_wr_entry (rt_wr_entry), .rt_wr_ack (rt_wr_ack), .hdr_info (hdr_info),
      .hdr_vld (hdr_vld), .result (lpm_result), .result_vld (lpm_result_vld)
   );

   // one decision per packet, 4 deep is plenty at 8+ words per packet
   small_fifo #(.width(res_w), .depth_bits(2)) i_result_fifo (
      .clk (clk), .rst_n (rst_n), .din (lpm_result), .wr_en (lpm_result_vld),
      .rd_en (result_rd_en), .dout (fifo_result), .empty (result_empty),
      .nearly_full ()
   );

   //////////////////////////////////////////////////////////////////////
   // output side
   //////////////////////////////////////////////////////////////////////
   op_lut_process_sm i_process_sm (
      .clk (clk), .rst_n (rst_n), .fifo_word (fifo_word), .fifo_empty (fifo_empty),
      .fifo_rd_en (fifo_rd_en), .result (fifo_result), .result_empty (result_empty),
      .result_rd_en (result_rd_en), .out_word (out_word), .out_wr (out_wr),
      .out_rdy (out_rdy)
   );

endmodule

/* tb_pkt_model.svh */
`ifndef tb_pkt_model_svh
`define tb_pkt_model_svh

////////////////////////////////////////////////////////////////////
// packet under construction, expected output and table mirror
////////////////////////////////////////////////////////////////////
router_op_lut_pkg::pkt_word_t    pkt_buf [$];   // words of the packet being built
router_op_lut_pkg::pkt_word_t    exp_q [$];     // expected output words, in order
router_op_lut_pkg::route_entry_t rt_model [4];  // mirror of the DUT route table

// builds one packet with the header fields at their word positions
function automatic void build_pkt(input logic [47:0] da, input logic [15:0] etype,
                                  input logic [7:0] vihl, input logic [7:0] ttl,
                                  input logic [15:0] cksum, input logic [31:0] dst_ip,
                                  input int len);
   router_op_lut_pkg::pkt_word_t w;
   pkt_buf.delete();
   for (int i = 0; i < len; i++) begin
      w.ctrl = 8'h00;                  // mid packet
      w.data = {$urandom, $urandom};   // random filler around the fields
      case (i)
         0: w.ctrl = router_op_lut_pkg::ctrl_mod_hdr;
         1: w.data[63:16] = da;
         2: begin
            w.data[31:16] = etype;
            w.data[15:8]  = vihl;
         end
         3: w.data[15:8] = ttl;
         4: begin
            w.data[63:48] = cksum;
            w.data[15:0]  = dst_ip[31:16];   // upper half of the dst ip
         end
         5: w.data[63:48] = dst_ip[15:0];
         default: ;
      endcase
      if (i == len - 1) w.ctrl = 8'(8'h01 << ($urandom % 8));   // one-hot eop byte
      pkt_buf.push_back(w);
   end
endfunction

// checksum after the ttl drops by one: +0x0100, a wrap past 16 bits adds one back
function automatic logic [15:0] cksum_after_ttl_dec(input logic [15:0] c);
   if (c >= 16'hff00) return c + 16'h0101;   // 0x10000 folds over to 0x0001
   return c + 16'h0100;
endfunction

// applies the lookup rules to pkt_buf and queues the rewritten words
function automatic router_op_lut_pkg::action_e predict_pkt();
   logic [47:0] da;
   logic [15:0] etype;
   logic [7:0]  vihl;
   logic [7:0]  ttl;
   logic [31:0] dip;
   logic        hit;
   logic [7:0]  port;
   router_op_lut_pkg::action_e   act;
   router_op_lut_pkg::pkt_word_t w;
   da    = pkt_buf[1].data[63:16];
   etype = pkt_buf[2].data[31:16];
   vihl  = pkt_buf[2].data[15:8];
   ttl   = pkt_buf[3].data[15:8];
   dip   = {pkt_buf[4].data[15:0], pkt_buf[5].data[63:48]};
   hit   = 1'b0;
   port  = 8'h00;
   for (int i = 0; i < 4; i++) begin   // first valid match in index order
      if (!hit && rt_model[i].valid && ((dip & rt_model[i].mask) == rt_model[i].prefix)) begin
         hit  = 1'b1;
         port = rt_model[i].oq;
      end
   end
   if (da != our_mac && da != bcast_mac) begin
      act = router_op_lut_pkg::act_drop;
   end else if (da == bcast_mac || etype != 16'h0800 || vihl != 8'h45 || ttl <= 8'd1 || !hit) begin
      act  = router_op_lut_pkg::act_to_cpu;
      port = cpu_oq;
   end else begin
      act = router_op_lut_pkg::act_forward;
   end
   if (act == router_op_lut_pkg::act_drop) return act;   // nothing comes out
   foreach (pkt_buf[i]) begin
      w = pkt_buf[i];
      if (i == 0) w.data[7:0] = port;
      if (act == router_op_lut_pkg::act_forward && i == 3) w.data[15:8] = ttl - 8'd1;
      if (act == router_op_lut_pkg::act_forward && i == 4)
         w.data[63:48] = cksum_after_ttl_dec(w.data[63:48]);
      exp_q.push_back(w);
   end
   return act;
endfunction

`endif

/* tb_router_op_lut.sv */
`timescale 1ns/1ps

module tb_router_op_lut;

   localparam int          cpu_port    = 0;
   localparam logic [7:0]  cpu_oq      = 8'h01 << cpu_port;
   localparam logic [47:0] our_mac     = 48'h0012_3456_789a;
   localparam logic [47:0] bcast_mac   = {48{1'b1}};
   localparam logic [47:0] other_mac   = 48'h0a0b_0c0d_0e0f;   // not ours, gets dropped
   localparam logic [15:0] etype_ip    = 16'h0800;
   localparam int          wait_limit  = 2000;   // cycles per single wait
   localparam int          drain_limit = 8000;

   logic                              clk;
   logic                              rst_n;
   router_op_lut_pkg::pkt_word_t      in_word;
   logic                              in_wr;
   logic                              in_rdy;
   router_op_lut_pkg::pkt_word_t      out_word;
   logic                              out_wr;
   logic                              out_rdy;
   logic [47:0]                       router_mac;
   logic                              rt_wr_req;
   logic [1:0]                        rt_wr_addr;
   router_op_lut_pkg::route_entry_t   rt_wr_entry;
   logic                              rt_wr_ack;

   router_op_lut_pkg::pkt_word_t exp_w;
   bit rdy_random;                     // random out_rdy while set
   bit timed_out;
   int err_cnt, timeout_cnt, words_checked;
   int n_fwd, n_cpu, n_drop;

`include "tb_pkt_model.svh"

   router_op_lut #(.num_queues(8), .cpu_port(cpu_port), .lut_depth(4)) i_router_op_lut (
      .clk (clk), .rst_n (rst_n), .in_word (in_word), .in_wr (in_wr), .in_rdy (in_rdy),
      .out_word (out_word), .out_wr (out_wr), .out_rdy (out_rdy), .router_mac (router_mac),
      .rt_wr_req (rt_wr_req), .rt_wr_addr (rt_wr_addr), .rt_wr_entry (rt_wr_entry),
      .rt_wr_ack (rt_wr_ack)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // checks and helpers
   //////////////////////////////////////////////////////////////////////
   task automatic check_val(input string name, input logic [71:0] got, input logic [71:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %0h expected %0h at %0t", name, got, exp, $time);
         err_cnt++;
      end
   endtask

   task automatic flag_timeout(input string what);
      $display("ERROR: timed out, %s", what);
      timeout_cnt++;
      timed_out = 1'b1;   // later steps are skipped
   endtask

   function automatic router_op_lut_pkg::route_entry_t route(input logic [31:0] prefix,
                                                            input logic [31:0] mask,
                                                            input logic [7:0] oq);
      router_op_lut_pkg::route_entry_t e;
      e.valid  = 1'b1;
      e.prefix = prefix;
      e.mask   = mask;
      e.oq     = oq;
      return e;
   endfunction

   // req/ack write, called 2 ns after a rising edge
   task automatic write_route(input logic [1:0] addr, input router_op_lut_pkg::route_entry_t e);
      int cyc;
      if (timed_out) return;
      rt_wr_addr  = addr;
      rt_wr_entry = e;
      rt_wr_req   = 1'b1;
      cyc = 0;
      @(negedge clk);   // request cycle, ack still low here
      while (!rt_wr_ack && cyc < wait_limit) begin
         @(negedge clk);
         cyc++;
      end
      if (!rt_wr_ack) begin
         rt_wr_req = 1'b0;
         flag_timeout("no ack for a route table write");
         return;
      end
      check_val("rt_wr_ack delay", 72'(cyc), 72'd1);
      rt_model[addr] = e;
      @(posedge clk);
      #2 rt_wr_req = 1'b0;
      @(negedge clk);
      check_val("rt_wr_ack", 72'(rt_wr_ack), 72'd0);   // one cycle pulse only
      @(posedge clk);
      #2;
   endtask

   // pushes pkt_buf into the DUT, honoring in_rdy
   task automatic send_pkt(input int gap);
      int waited;
      foreach (pkt_buf[i]) begin
         waited = 0;
         while (!in_rdy && waited < wait_limit) begin
            in_wr = 1'b0;
            @(posedge clk);
            #2;
            waited++;
         end
         if (!in_rdy) begin
            in_wr = 1'b0;
            flag_timeout("in_rdy stayed low while sending a packet");
            return;
         end
         in_word = pkt_buf[i];
         in_wr   = 1'b1;
         @(posedge clk);
         #2;
      end
      in_wr = 1'b0;
      repeat (gap) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic send_one(input logic [47:0] da, input logic [15:0] etype,
                           input logic [7:0] vihl, input logic [7:0] ttl,
                           input logic [15:0] cksum, input logic [31:0] dip,
                           input int len, input int gap);
      router_op_lut_pkg::action_e act;
      if (timed_out) return;
      build_pkt(da, etype, vihl, ttl, cksum, dip, len);
      act = predict_pkt();
      case (act)
         router_op_lut_pkg::act_forward: n_fwd++;
         router_op_lut_pkg::act_to_cpu:  n_cpu++;
         default:                        n_drop++;
      endcase
      send_pkt(gap);
   endtask

   task automatic random_traffic(input int n_pkts);
      logic [47:0] da;
      logic [31:0] dip;
      int          pick;
      for (int p = 0; p < n_pkts; p++) begin
         pick = $urandom % 8;
         da = (pick == 0) ? other_mac : ((pick == 1) ? bcast_mac : our_mac);
         case ($urandom % 4)
            0:       dip = {24'h0a0101, 8'($urandom)};
            1:       dip = {16'h0a01, 16'($urandom)};
            2:       dip = {8'h0a, 24'($urandom)};
            default: dip = {16'hac10, 16'($urandom)};   // route miss
         endcase
         send_one(da, etype_ip, 8'h45, 8'($urandom % 8), 16'($urandom), dip,
                  8 + int'($urandom % 10), 0);   // back to back
      end
   endtask

   // waits until every expected word has left, then a quiet window
   task automatic wait_drain();
      int cyc;
      if (timed_out) return;
      cyc = 0;
      while (exp_q.size() != 0 && cyc < drain_limit) begin
         @(negedge clk);
         cyc++;
      end
      if (exp_q.size() != 0) begin
         flag_timeout("expected packets never left the DUT");
         return;
      end
      repeat (20) @(negedge clk);   // catches stray or dropped-packet words
      @(posedge clk);
      #2;
   endtask

   //////////////////////////////////////////////////////////////////////
   // output side, out_rdy driver and compare process
   //////////////////////////////////////////////////////////////////////
   always @(posedge clk) begin
      #2;
      out_rdy = rdy_random ? (($urandom % 3) != 0) : 1'b1;
   end

   always @(negedge clk) begin   // outputs settled, mid cycle
      if (rst_n && out_wr) begin
         if (!out_rdy) begin
            $display("ERROR: out_wr high while out_rdy low at %0t", $time);
            err_cnt++;
         end
         if (exp_q.size() == 0) begin
            $display("ERROR: unexpected output word %0h at %0t", out_word, $time);
            err_cnt++;
         end else begin
            exp_w = exp_q.pop_front();
            check_val("out_word", out_word, exp_w);
            words_checked++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'h54676531));
      rst_n = 1'b0;
      in_word = '0;
      in_wr = 1'b0;
      out_rdy = 1'b1;
      router_mac = our_mac;
      rt_wr_req = 1'b0;
      rt_wr_addr = 2'd0;
      rt_wr_entry = '0;
      foreach (rt_model[i]) rt_model[i] = '0;
      repeat (8) @(posedge clk);
      #2 rst_n = 1'b1;
      @(negedge clk);
      check_val("out_wr", 72'(out_wr), 72'd0);
      check_val("rt_wr_ack", 72'(rt_wr_ack), 72'd0);
      check_val("in_rdy", 72'(in_rdy), 72'd1);
      @(posedge clk);
      #2;
      // overlapping prefixes, index 3 is longest but loses to index 0
      write_route(2'd0, route(32'h0a01_0100, 32'hffff_ff00, 8'h04));
      write_route(2'd1, route(32'h0a01_0000, 32'hffff_0000, 8'h10));
      write_route(2'd2, route(32'h0a00_0000, 32'hff00_0000, 8'h40));
      write_route(2'd3, route(32'h0a01_0180, 32'hffff_ff80, 8'h80));
      // forwarding, checksums near the wrap
      send_one(our_mac, etype_ip, 8'h45, 8'd64, 16'h1234, 32'h0a01_0105, 8, 2);
      send_one(our_mac, etype_ip, 8'h45, 8'd17, 16'hff00, 32'h0a01_0709, 9, 0);
      send_one(our_mac, etype_ip, 8'h45, 8'd128, 16'hffff, 32'h0ac8_0001, 12, 1);
      send_one(our_mac, etype_ip, 8'h45, 8'd2, 16'hff80, 32'h0a01_01c8, 10, 0);
      // cpu path
      send_one(bcast_mac, etype_ip, 8'h45, 8'd64, 16'h4000, 32'h0a01_0105, 8, 0);
      send_one(our_mac, 16'h86dd, 8'h45, 8'd64, 16'h4001, 32'h0a01_0105, 8, 0);
      send_one(our_mac, etype_ip, 8'h46, 8'd64, 16'h4002, 32'h0a01_0105, 9, 0);
      send_one(our_mac, etype_ip, 8'h45, 8'd1, 16'h4003, 32'h0a01_0105, 8, 0);
      send_one(our_mac, etype_ip, 8'h45, 8'd0, 16'h4004, 32'h0a01_0105, 8, 0);
      send_one(our_mac, etype_ip, 8'h45, 8'd64, 16'h4005, 32'hac10_0001, 8, 0);
      // wrong mac, then a good one right behind it
      send_one(other_mac, etype_ip, 8'h45, 8'd64, 16'h5000, 32'h0a01_0105, 11, 0);
      send_one(our_mac, etype_ip, 8'h45, 8'd33, 16'hfffe, 32'h0a01_0203, 8, 0);
      wait_drain();
      // back-pressure with random out_rdy
      rdy_random = 1'b1;
      random_traffic(40);
      wait_drain();
      rdy_random = 1'b0;
      $display("packets fwd %0d cpu %0d drop %0d, words checked %0d, errors %0d, timeouts %0d",
               n_fwd, n_cpu, n_drop, words_checked, err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

/* tb.f */
+incdir+.
router_op_lut_pkg.sv
small_fifo.sv
pkt_word_counter.sv
hdr_parser.sv
ip_lpm.sv
op_lut_process_sm.sv
router_op_lut.sv
tb_router_op_lut.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_router_op_lut -f tb.f -o sim_router_op_lut
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_router_op_lut)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

echo "$out" | grep -q "^Result: PASSED$" || exit 1
exit 0
